// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --assert -j 0
TOP      := mips_pipeline_tb
FILELIST := mips_pipeline.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
RUN_ARGS := +verilator+error+limit+100
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "RESULT: FAIL"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "RESULT: FAIL, run ended early"; exit 1; fi
	@echo "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/decode_stage.sv ====
//####################
// operands come from the register file or from the memory stage, never from execute
//####################
`timescale 1ns/1ps

module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     d_instr,
    input  logic                stall,
    input  logic                fwd_rs,
    input  logic                fwd_rt,
    input  mips_pkg::word_t     mem_fwd_data,
    input  mips_pkg::reg_addr_t dbg_addr,
    output mips_pkg::word_t     dbg_data,
    wb_if.sink                  wb,
    id_ex_if.source             id_ex
);
    import mips_pkg::*;

    ctrl_t     ctrl;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t rd_addr;
    reg_addr_t dest;
    word_t     imm_ext;
    word_t     rf_rs;
    word_t     rf_rt;
    word_t     rs_op;
    word_t     rt_op;

    assign ctrl    = decode_ctrl(d_instr);
    assign rs_addr = d_instr[RS_LSB +: REG_ADDR_W];
    assign rt_addr = d_instr[RT_LSB +: REG_ADDR_W];
    assign rd_addr = d_instr[RD_LSB +: REG_ADDR_W];
    assign dest    = ctrl[CTRL_REG_DST_RD] ? rd_addr : rt_addr;  // R writes rd, I writes rt
    assign imm_ext = {{(XLEN-IMM_W){d_instr[IMM_W-1]}}, d_instr[IMM_W-1:0]};

    register_file i_regs (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .rs_addr   (rs_addr),
        .rt_addr   (rt_addr),
        .dbg_addr  (dbg_addr),
        .wb        (wb),
        .rs_val    (rf_rs),
        .rt_val    (rf_rt),
        .dbg_data  (dbg_data)
    );

    assign rs_op = fwd_rs ? mem_fwd_data : rf_rs;
    assign rt_op = fwd_rt ? mem_fwd_data : rf_rt;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            id_ex.valid <= 1'b0;   // bubble into execute
            id_ex.ctrl  <= '0;
        end
        else
        begin
            id_ex.valid <= 1'b1;
            id_ex.ctrl  <= ctrl;
        end
    end

    // operands, immediate and destination
    always_ff @(posedge SYS_clk)
    begin
        id_ex.rs_val <= rs_op;
        id_ex.rt_val <= rt_op;
        id_ex.imm    <= imm_ext;
        id_ex.dest   <= dest;
    end

endmodule

// ==== logic/execute_stage.sv ====
//####################
// no forwarding into execute; slt compares signed and writes 0 or 1
//####################
`timescale 1ns/1ps

module execute_stage (
    input  logic     SYS_clk,
    input  logic     SYS_reset,
    id_ex_if.sink    id_ex,
    ex_mem_if.source ex_mem
);
    import mips_pkg::*;

    alu_op_e alu_op;
    word_t   op_a;
    word_t   op_b;
    word_t   result;

    assign alu_op = alu_op_e'(id_ex.ctrl[CTRL_ALU_LSB +: ALU_OP_W]);
    assign op_a   = id_ex.rs_val;
    assign op_b   = id_ex.ctrl[CTRL_ALU_SRC_IMM] ? id_ex.imm : id_ex.rt_val;

    always_comb
    begin
        case (alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_SLT: result = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            default: result = '0;
        endcase
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            ex_mem.ctrl <= '0;
        else
            ex_mem.ctrl <= id_ex.valid ? id_ex.ctrl : '0;  // bubble stays inert
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_mem.alu_result <= result;
        ex_mem.store_data <= id_ex.rt_val;   // sw data comes from rt
        ex_mem.dest       <= id_ex.dest;
    end

endmodule

// ==== logic/fetch_unit.sv ====
//####################
// instr_data must follow instr_addr in the same cycle, no handshake
//####################
`timescale 1ns/1ps

module fetch_unit (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    input  logic           stall,
    input  mips_pkg::word_t instr_data,
    output mips_pkg::pc_t   instr_addr,
    output mips_pkg::word_t d_instr
);
    import mips_pkg::*;

    pc_t pc;

    assign instr_addr = pc;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            pc      <= '0;
            d_instr <= '0;        // zero word decodes as a no-op
        end
        else if (!stall)
        begin
            pc      <= pc + pc_t'(4);
            d_instr <= instr_data;
        end
        // stall: pc and decode instruction hold
    end

endmodule

// ==== logic/hazard_unit.sv ====
//####################
// one-cycle stall on an execute-stage producer, then forward from memory into decode
//####################
`timescale 1ns/1ps

module hazard_unit (
    input  mips_pkg::word_t d_instr,
    id_ex_if.monitor        id_ex,
    ex_mem_if.monitor       ex_mem,
    output logic            stall,
    output logic            fwd_rs,
    output logic            fwd_rt
);
    import mips_pkg::*;

    ctrl_t     d_ctrl;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      reads_rs;
    logic      reads_rt;
    logic      ex_writes;
    logic      mem_writes;

    assign d_ctrl = decode_ctrl(d_instr);
    assign rs     = d_instr[RS_LSB +: REG_ADDR_W];
    assign rt     = d_instr[RT_LSB +: REG_ADDR_W];

    // every real op either writes a reg or stores, and both read rs
    assign reads_rs = d_ctrl[CTRL_REG_WRITE] | d_ctrl[CTRL_MEM_WRITE];
    assign reads_rt = d_ctrl[CTRL_USES_RT];

    assign ex_writes  = id_ex.valid && id_ex.ctrl[CTRL_REG_WRITE] && id_ex.dest != '0;
    assign mem_writes = ex_mem.ctrl[CTRL_REG_WRITE] && ex_mem.dest != '0;

    // execute gets a bubble next cycle, so this never holds two cycles in a row
    assign stall = ex_writes &&
                   ((reads_rs && id_ex.dest == rs) || (reads_rt && id_ex.dest == rt));

    assign fwd_rs = mem_writes && reads_rs && ex_mem.dest == rs;
    assign fwd_rt = mem_writes && reads_rt && ex_mem.dest == rt;

endmodule

// ==== logic/memory_stage.sv ====
//####################
// 64-word data memory, word index from address bits 7:2; upper address bits ignored
//####################
`timescale 1ns/1ps

module memory_stage (
    input  logic            SYS_clk,
    input  logic            SYS_reset,
    ex_mem_if.sink          ex_mem,
    wb_if.source            wb,
    output mips_pkg::word_t mem_fwd_data
);
    import mips_pkg::*;

    word_t                  dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] dmem_idx;
    word_t                  load_data;

    assign dmem_idx  = ex_mem.alu_result[DMEM_ADDR_W+1:2];
    assign load_data = dmem[dmem_idx];   // async read

    always_ff @(posedge SYS_clk)
    begin
        if (ex_mem.ctrl[CTRL_MEM_WRITE])
            dmem[dmem_idx] <= ex_mem.store_data;
    end

    // also the value forwarded back into decode
    assign mem_fwd_data = ex_mem.ctrl[CTRL_MEM_TO_REG] ? load_data : ex_mem.alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            wb.reg_write <= 1'b0;
        else
            wb.reg_write <= ex_mem.ctrl[CTRL_REG_WRITE];
    end

    always_ff @(posedge SYS_clk)
    begin
        wb.dest <= ex_mem.dest;
        wb.data <= mem_fwd_data;
    end

endmodule

// ==== logic/mips_pipeline.sv ====
//####################
// five-stage pipeline top; instruction memory lives outside, dbg_data is combinational
//####################
`timescale 1ns/1ps

module mips_pipeline (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     instr_data,
    input  mips_pkg::reg_addr_t dbg_addr,
    output mips_pkg::pc_t       instr_addr,
    output mips_pkg::word_t     dbg_data
);
    import mips_pkg::*;

    word_t d_instr;
    word_t mem_fwd_data;
    logic  stall;
    logic  fwd_rs;
    logic  fwd_rt;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    wb_if     wb ();

    fetch_unit i_fetch (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .stall      (stall),
        .instr_data (instr_data),
        .instr_addr (instr_addr),
        .d_instr    (d_instr)
    );

    hazard_unit i_hazard (
        .d_instr (d_instr),
        .id_ex   (id_ex),
        .ex_mem  (ex_mem),
        .stall   (stall),
        .fwd_rs  (fwd_rs),
        .fwd_rt  (fwd_rt)
    );

    decode_stage i_decode (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .d_instr      (d_instr),
        .stall        (stall),
        .fwd_rs       (fwd_rs),
        .fwd_rt       (fwd_rt),
        .mem_fwd_data (mem_fwd_data),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data),
        .wb           (wb),
        .id_ex        (id_ex)
    );

    execute_stage i_execute (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem)
    );

    memory_stage i_memory (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .ex_mem       (ex_mem),
        .wb           (wb),
        .mem_fwd_data (mem_fwd_data)
    );

endmodule

// ==== logic/mips_pkg.sv ====
//####################
// shared types and encodings of the pipeline; the only opcodes are R-type, addi, lw and sw
// an opcode or funct outside this set decodes to an all-zero control word (no-op)
//####################
package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [XLEN-1:0]       pc_t;      // byte address
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    // instruction field positions
    localparam int OPC_LSB   = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_W     = 16;  // imm sits at bit 0

    localparam int ALU_OP_W = 3;
    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // control word bit positions
    localparam int CTRL_REG_WRITE   = 0;
    localparam int CTRL_MEM_TO_REG  = 1;
    localparam int CTRL_MEM_WRITE   = 2;
    localparam int CTRL_ALU_SRC_IMM = 3;
    localparam int CTRL_REG_DST_RD  = 4;
    localparam int CTRL_USES_RT     = 5;  // rt is a source operand
    localparam int CTRL_ALU_LSB     = 6;
    localparam int CTRL_W           = CTRL_ALU_LSB + ALU_OP_W;

    typedef logic [CTRL_W-1:0] ctrl_t;

    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;

    // opcode/funct to control word, also used by the hazard logic to find source regs
    function automatic ctrl_t decode_ctrl(word_t instr);
        opcode_t opc;
        funct_t  fn;
        ctrl_t   c;
        alu_op_e op;
        logic    rtype_ok;
        opc      = instr[OPC_LSB +: $bits(opcode_t)];
        fn       = instr[FUNCT_LSB +: $bits(funct_t)];
        c        = '0;
        op       = ALU_ADD;
        rtype_ok = 1'b1;
        case (opc)
            OP_RTYPE:
            begin
                case (fn)
                    FN_ADD:  op = ALU_ADD;
                    FN_SUB:  op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_SLT:  op = ALU_SLT;
                    default: rtype_ok = 1'b0;
                endcase
                c[CTRL_REG_WRITE]  = rtype_ok;
                c[CTRL_REG_DST_RD] = rtype_ok;
                c[CTRL_USES_RT]    = rtype_ok;
            end
            OP_ADDI:
            begin
                c[CTRL_REG_WRITE]   = 1'b1;
                c[CTRL_ALU_SRC_IMM] = 1'b1;
            end
            OP_LW:
            begin
                c[CTRL_REG_WRITE]   = 1'b1;
                c[CTRL_MEM_TO_REG]  = 1'b1;
                c[CTRL_ALU_SRC_IMM] = 1'b1;
            end
            OP_SW:
            begin
                c[CTRL_MEM_WRITE]   = 1'b1;
                c[CTRL_ALU_SRC_IMM] = 1'b1;
                c[CTRL_USES_RT]     = 1'b1;  // store data
            end
            default: c = '0;
        endcase
        c[CTRL_ALU_LSB +: ALU_OP_W] = op;
        return c;
    endfunction

endpackage

// ==== logic/register_file.sv ====
//####################
// r0 reads zero; a write-back in the same cycle is passed through to all read ports
//####################
`timescale 1ns/1ps

module register_file (
    input  logic                 SYS_clk,
    input  logic                 SYS_reset,
    input  mips_pkg::reg_addr_t  rs_addr,
    input  mips_pkg::reg_addr_t  rt_addr,
    input  mips_pkg::reg_addr_t  dbg_addr,
    wb_if.sink                   wb,
    output mips_pkg::word_t      rs_val,
    output mips_pkg::word_t      rt_val,
    output mips_pkg::word_t      dbg_data
);
    import mips_pkg::*;

    word_t regs [2**REG_ADDR_W];

    function automatic word_t read_port(reg_addr_t addr);
        word_t val;
        if (addr == '0)
            val = '0;
        else if (wb.reg_write && wb.dest == addr)
            val = wb.data;       // bypass
        else
            val = regs[addr];
        return val;
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
                regs[i] <= '0;
        end
        else if (wb.reg_write && wb.dest != '0)
        begin
            regs[wb.dest] <= wb.data;
        end
    end

    always_comb
    begin
        rs_val   = read_port(rs_addr);
        rt_val   = read_port(rt_addr);
        dbg_data = read_port(dbg_addr);
    end

endmodule

// ==== logic/stage_if.sv ====
//####################
// stage register bundles; no clock inside, each stage owns its own flops
//####################
`timescale 1ns/1ps

interface id_ex_if;
    import mips_pkg::*;

    logic      valid;
    ctrl_t     ctrl;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;     // already sign extended
    reg_addr_t dest;

    modport source  (output valid, ctrl, rs_val, rt_val, imm, dest);
    modport sink    (input  valid, ctrl, rs_val, rt_val, imm, dest);
    modport monitor (input  valid, ctrl, dest);
endinterface

interface ex_mem_if;
    import mips_pkg::*;

    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dest;

    modport source  (output ctrl, alu_result, store_data, dest);
    modport sink    (input  ctrl, alu_result, store_data, dest);
    modport monitor (input  ctrl, dest);
endinterface

interface wb_if;
    import mips_pkg::*;

    logic      reg_write;
    reg_addr_t dest;
    word_t     data;

    modport source (output reg_write, dest, data);
    modport sink   (input  reg_write, dest, data);
endinterface

// ==== mips_pipeline.f ====
logic/mips_pkg.sv
logic/stage_if.sv
logic/fetch_unit.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/mips_pipeline.sv
sim/mips_pipeline_asserts.sv
sim/mips_pipeline_tb.sv

// ==== sim/mips_pipeline_asserts.sv ====
//####################
// bound into the pipeline top; watches fetch and stall sequencing only
//####################
`timescale 1ns/1ps

module mips_pipeline_asserts (
    input logic          SYS_clk,
    input logic          SYS_reset,
    input logic          stall,
    input mips_pkg::pc_t instr_addr
);
    int fail_count = 0;

    // bubble in execute clears the hazard
    a_stall_single: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> !stall)
        else
        begin
            $error("stall stayed high for two cycles");
            fail_count++;
        end

    a_pc_hold: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> $stable(instr_addr))
        else
        begin
            $error("instr_addr moved during a stall");
            fail_count++;
        end

    a_pc_step: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !stall |=> instr_addr == $past(instr_addr) + 32'd4)
        else
        begin
            $error("instr_addr did not advance by 4");
            fail_count++;
        end

    a_pc_reset: assert property (@(posedge SYS_clk)
        SYS_reset |=> instr_addr == '0)
        else
        begin
            $error("instr_addr not zero after reset");
            fail_count++;
        end

endmodule

bind mips_pipeline mips_pipeline_asserts i_asserts (
    .SYS_clk    (SYS_clk),
    .SYS_reset  (SYS_reset),
    .stall      (stall),
    .instr_addr (instr_addr)
);

// ==== sim/mips_pipeline_tb.sv ====
//####################
// runs a fixed program from an instruction table, then reads r0..r17 over the debug port
// immediates come from a Galois LFSR with a fixed seed, so every run is the same
//####################
`timescale 1ns/1ps

module mips_pipeline_tb;
    import mips_pkg::*;

    localparam int PROG_LEN   = 19;
    localparam int PROG_SLOTS = 64;   // one per instr_addr[7:2]
    localparam int NUM_STALLS = 3;
    localparam int NUM_REGS   = 18;
    localparam int LIMIT      = PROG_LEN + NUM_STALLS + 8;

    logic      SYS_clk    = 1'b0;
    logic      SYS_reset;
    word_t     instr_data = '0;
    reg_addr_t dbg_addr;
    pc_t       instr_addr;
    word_t     dbg_data;

    word_t       prog [PROG_SLOTS];
    word_t       exp_val [NUM_REGS];   // indexed by register number
    logic [31:0] lfsr    = 32'h4518;
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    logic [15:0] imm_n;
    logic [15:0] imm_c;
    int          errors  = 0;
    int          cycles  = 0;
    logic        drained = 1'b0;

    mips_pipeline i_dut (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .instr_data (instr_data),
        .dbg_addr   (dbg_addr),
        .instr_addr (instr_addr),
        .dbg_data   (dbg_data)
    );

    always #10 SYS_clk = ~SYS_clk;

    // one Galois step per bit taken
    function automatic logic [15:0] next_imm();
        logic [15:0] bits;
        bits = '0;
        for (int i = 0; i < 16; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            bits = {bits[14:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic word_t sign_extend(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    function automatic word_t rtype_word(int rs, int rt, int rd, funct_t fn);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t itype_word(opcode_t op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic check_value(string name, word_t got, word_t want);
        if (got !== want)
        begin
            errors++;
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // instruction memory, past the program it returns no-ops
    always @(negedge SYS_clk)
    begin
        if (instr_addr[31:8] == '0)
            instr_data <= prog[instr_addr[7:2]];
        else
            instr_data <= '0;
    end

    // watchdog on the drain
    always @(posedge SYS_clk)
    begin
        if (SYS_reset === 1'b0 && !drained)
        begin
            cycles++;
            if (cycles > LIMIT)
            begin
                $display("timeout, pipeline did not drain within %0d cycles", LIMIT);
                $display("Testbench failed");
                $finish;
            end
        end
    end

    initial
    begin
        SYS_reset = 1'b1;
        dbg_addr  = '0;

        imm_a = next_imm();
        imm_b = next_imm();
        imm_n = next_imm() | 16'h8000;   // always negative
        imm_c = next_imm();

        for (int k = 0; k < PROG_SLOTS; k++)
            prog[k] = '0;
        prog[0]  = itype_word(OP_ADDI, 0, 1, imm_a);
        prog[1]  = itype_word(OP_ADDI, 0, 2, imm_b);
        prog[2]  = itype_word(OP_ADDI, 0, 3, imm_n);
        prog[3]  = itype_word(OP_ADDI, 0, 4, 16'd16);   // data base, word 4
        prog[4]  = itype_word(OP_ADDI, 0, 5, 16'd7);
        prog[5]  = rtype_word(1, 2, 6, FN_ADD);
        prog[6]  = rtype_word(1, 2, 7, FN_SUB);
        prog[7]  = rtype_word(1, 2, 8, FN_AND);
        prog[8]  = rtype_word(1, 2, 9, FN_OR);
        prog[9]  = rtype_word(3, 5, 10, FN_SLT);        // negative vs 7
        prog[10] = rtype_word(1, 2, 11, FN_SLT);
        prog[11] = itype_word(OP_ADDI, 3, 12, imm_c);
        prog[12] = rtype_word(12, 5, 13, FN_ADD);       // addi into R-type, stall
        prog[13] = rtype_word(12, 13, 14, FN_SUB);      // rt dependency, stall again
        prog[14] = itype_word(OP_SW, 4, 13, 16'd0);
        prog[15] = itype_word(OP_LW, 4, 15, 16'd0);
        prog[16] = rtype_word(15, 5, 16, FN_ADD);       // load-use
        prog[17] = itype_word(OP_ADDI, 1, 0, 16'd5);    // r0 target
        prog[18] = rtype_word(0, 3, 17, FN_OR);

        exp_val[0]  = '0;
        exp_val[1]  = sign_extend(imm_a);
        exp_val[2]  = sign_extend(imm_b);
        exp_val[3]  = sign_extend(imm_n);
        exp_val[4]  = 32'd16;
        exp_val[5]  = 32'd7;
        exp_val[6]  = exp_val[1] + exp_val[2];
        exp_val[7]  = exp_val[1] - exp_val[2];
        exp_val[8]  = exp_val[1] & exp_val[2];
        exp_val[9]  = exp_val[1] | exp_val[2];
        exp_val[10] = 32'd1;
        exp_val[11] = ($signed(exp_val[1]) < $signed(exp_val[2])) ? 32'd1 : 32'd0;
        exp_val[12] = exp_val[3] + sign_extend(imm_c);
        exp_val[13] = exp_val[12] + 32'd7;
        exp_val[14] = exp_val[12] - exp_val[13];
        exp_val[15] = exp_val[13];                      // stored, then loaded
        exp_val[16] = exp_val[13] + 32'd7;
        exp_val[17] = exp_val[3];

        repeat (3) @(posedge SYS_clk);
        @(negedge SYS_clk);
        SYS_reset = 1'b0;

        // program opens with five independent addi
        for (int i = 0; i < 5; i++)
        begin
            check_value("instr_addr", instr_addr, pc_t'(4 * i));
            @(negedge SYS_clk);
        end

        // last instruction left decode once fetch is past it, write lands 3 cycles on
        while (instr_addr != pc_t'(4 * (PROG_LEN + 1)))
            @(negedge SYS_clk);
        repeat (3) @(negedge SYS_clk);
        drained = 1'b1;

        for (int r = 0; r < NUM_REGS; r++)
        begin
            dbg_addr = reg_addr_t'(r);
            @(negedge SYS_clk);
            check_value($sformatf("dbg_data[r%0d]", r), dbg_data, exp_val[r]);
        end

        $display("checks done, %0d value errors, %0d assertion failures",
                 errors, i_dut.i_asserts.fail_count);
        if (errors == 0 && i_dut.i_asserts.fail_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
